// ==== src/comp_engine_pkg.sv ====
package comp_engine_pkg;

    // --------------------------------------------------
    // bus transfer codes
    // --------------------------------------------------
    typedef logic [1:0] htrans_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // --------------------------------------------------
    // data types
    // --------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // one compressor word, either whole or as two bus beats
    typedef union packed {
        logic [63:0] dword;
        struct packed {
            word_t hi;
            word_t lo;
        } beats;
    } comp_word_u;

    // 0..31 over a block read, 0..15 over a write
    typedef logic [4:0] beat_idx_t;
    typedef logic [1:0] comp_sel_t;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int NUM_COMP   = 3;
    localparam int BURST_LEN  = 16;
    // 128 byte raw block, 64 byte compressed block
    localparam int BLK_SHIFT  = 7;
    localparam int CBLK_SHIFT = 6;
    localparam int BUF_AW     = 3;

endpackage

// ==== src/burst_cmd_if.sv ====
interface burst_cmd_if;
    import comp_engine_pkg::*;

    // one-cycle command pulse
    logic      cmd_valid;
    addr_t     cmd_addr;
    logic      cmd_write;
    // 16 for the second half of a block read
    beat_idx_t cmd_beat_base;
    // one-cycle pulse once the last data phase is through
    logic      cmd_done;

    modport source (
        output cmd_valid,
        output cmd_addr,
        output cmd_write,
        output cmd_beat_base,
        input  cmd_done
    );

    modport sink (
        input  cmd_valid,
        input  cmd_addr,
        input  cmd_write,
        input  cmd_beat_base,
        output cmd_done
    );

endinterface

// ==== src/beat_if.sv ====
interface beat_if;
    import comp_engine_pkg::*;

    // one cycle per accepted read data phase
    logic      rd_beat_en;
    // data phase index on reads, address phase index on writes
    beat_idx_t beat_idx;
    word_t     rd_data;
    // write beat picked for the current beat_idx
    word_t     wr_word;

    modport master (
        output rd_beat_en,
        output beat_idx,
        output rd_data,
        input  wr_word
    );

    modport port (
        input  rd_beat_en,
        input  beat_idx,
        input  rd_data,
        output wr_word
    );

endinterface

// ==== src/block_sequencer.sv ====
module block_sequencer #(
    parameter int BLK_CNT_W = 25
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  comp_engine_pkg::addr_t                src_addr_i,
    input  comp_engine_pkg::addr_t                dst_addr_i,
    input  logic [BLK_CNT_W-1:0]                  len_i,
    input  logic                                  start_i,
    output logic                                  done_o,
    input  logic [comp_engine_pkg::NUM_COMP-1:0]  comp_done_i,
    input  logic [comp_engine_pkg::NUM_COMP-1:0]  comp_fail_i,
    output comp_engine_pkg::comp_sel_t            owner_o,
    burst_cmd_if.source                           cmd
);
    import comp_engine_pkg::*;

    // byte offset of the second read burst inside a block
    localparam addr_t HALF_BLK = addr_t'(BURST_LEN * 4);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_LO,
        S_RD_HI,
        S_WAIT,
        S_WR
    } state_t;

    state_t               state;
    logic [BLK_CNT_W-1:0] blk_cnt;
    logic [BLK_CNT_W-1:0] blk_nxt;
    logic                 issue;
    addr_t                blk_src;
    addr_t                blk_dst;
    comp_sel_t            owner_pick;
    logic                 all_done;

    assign blk_nxt  = blk_cnt + 1'b1;
    assign blk_src  = src_addr_i + (addr_t'(blk_cnt) << BLK_SHIFT);
    assign blk_dst  = dst_addr_i + (addr_t'(blk_cnt) << CBLK_SHIFT);
    assign all_done = &comp_done_i;

    // first compressor without a fail flag, 0 if none
    always_comb begin
        owner_pick = '0;
        for (int k = NUM_COMP - 1; k >= 0; k--) begin
            if (!comp_fail_i[k]) begin
                owner_pick = comp_sel_t'(k);
            end
        end
    end

    // --------------------------------------------------
    // block loop
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            blk_cnt <= '0;
            issue   <= 1'b0;
            owner_o <= '0;
        end else begin
            issue <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i && (len_i != '0)) begin
                        blk_cnt <= '0;
                        issue   <= 1'b1;
                        state   <= S_RD_LO;
                    end
                end
                S_RD_LO: begin
                    if (cmd.cmd_done) begin
                        issue <= 1'b1;
                        state <= S_RD_HI;
                    end
                end
                S_RD_HI: begin
                    if (cmd.cmd_done) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (all_done) begin
                        owner_o <= owner_pick;
                        issue   <= 1'b1;
                        state   <= S_WR;
                    end
                end
                default: begin
                    if (cmd.cmd_done) begin
                        blk_cnt <= blk_nxt;
                        if (blk_nxt == len_i) begin
                            state <= S_IDLE;
                        end else begin
                            issue <= 1'b1;
                            state <= S_RD_LO;
                        end
                    end
                end
            endcase
        end
    end

    // command fields follow the state entered with the pulse
    assign cmd.cmd_valid     = issue;
    assign cmd.cmd_write     = (state == S_WR);
    assign cmd.cmd_beat_base = (state == S_RD_HI) ? beat_idx_t'(BURST_LEN) : '0;
    assign cmd.cmd_addr      = (state == S_WR)    ? blk_dst :
                               (state == S_RD_HI) ? blk_src + HALF_BLK : blk_src;

    assign done_o = (state == S_IDLE) && !start_i;

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_owner_range: assert property (@(posedge clk) disable iff (!rst_n)
        owner_o < NUM_COMP);

    // one burst at a time, next command only after cmd_done
    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.cmd_valid |=> (!cmd.cmd_valid throughout cmd.cmd_done[->1]));

endmodule

// ==== src/ahb_burst_master.sv ====
module ahb_burst_master (
    input  logic                        clk,
    input  logic                        rst_n,
    burst_cmd_if.sink                   cmd,
    beat_if.master                      beat,
    output logic                        hbusreq_o,
    input  logic                        hgrant_i,
    output comp_engine_pkg::addr_t      haddr_o,
    output comp_engine_pkg::htrans_t    htrans_o,
    output logic                        hwrite_o,
    output comp_engine_pkg::word_t      hwdata_o,
    input  comp_engine_pkg::word_t      hrdata_i,
    input  logic                        hready_i
);
    import comp_engine_pkg::*;

    localparam int    LOC_W     = $clog2(BURST_LEN);
    localparam addr_t ADDR_STEP = addr_t'(4);

    // --------------------------------------------------
    // one burst
    // addr phase : | 0 | 1 | 2 | .. |15 |
    // data phase :     | 0 | 1 | .. |14 |15 |
    // state      : |1A |     MIDDLE     |LD |
    // --------------------------------------------------
    typedef enum logic [2:0] {
        S_IDLE,
        S_BUSREQ,
        S_FIRST_ADDR,
        S_MIDDLE,
        S_LAST_DATA
    } state_t;

    state_t          state;
    beat_idx_t       beat_cnt;
    logic [LOC_W-1:0] beat_loc;
    logic [LOC_W-1:0] last_mid;
    logic            addr_acc;
    logic            cmd_done_q;

    // index inside the current burst
    assign beat_loc = beat_cnt[LOC_W-1:0];
    // reads count data phases, writes count address phases
    assign last_mid = hwrite_o ? LOC_W'(BURST_LEN - 1) : LOC_W'(BURST_LEN - 2);
    assign addr_acc = hready_i && ((state == S_FIRST_ADDR) || (state == S_MIDDLE));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            beat_cnt   <= '0;
            hbusreq_o  <= 1'b0;
            haddr_o    <= '0;
            htrans_o   <= HTRANS_IDLE;
            hwrite_o   <= 1'b0;
            cmd_done_q <= 1'b0;
        end else begin
            cmd_done_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd.cmd_valid) begin
                        haddr_o   <= cmd.cmd_addr;
                        hwrite_o  <= cmd.cmd_write;
                        beat_cnt  <= cmd.cmd_beat_base;
                        hbusreq_o <= 1'b1;
                        state     <= S_BUSREQ;
                    end
                end
                S_BUSREQ: begin
                    if (hgrant_i) begin
                        htrans_o <= HTRANS_NONSEQ;
                        state    <= S_FIRST_ADDR;
                    end
                end
                S_FIRST_ADDR: begin
                    if (hready_i) begin
                        haddr_o  <= haddr_o + ADDR_STEP;
                        htrans_o <= HTRANS_SEQ;
                        // write index tracks the address phase
                        if (hwrite_o) begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                        state <= S_MIDDLE;
                    end
                end
                S_MIDDLE: begin
                    if (hready_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_loc == last_mid - 1'b1) begin
                            hbusreq_o <= 1'b0;
                        end
                        if (beat_loc == last_mid) begin
                            // 16th address accepted
                            htrans_o <= HTRANS_IDLE;
                            state    <= S_LAST_DATA;
                        end else begin
                            haddr_o <= haddr_o + ADDR_STEP;
                        end
                    end
                end
                default: begin
                    if (hready_i) begin
                        cmd_done_q <= 1'b1;
                        state      <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // write data follows its address phase by one cycle
    always_ff @(posedge clk) begin
        if (hwrite_o && addr_acc) begin
            hwdata_o <= beat.wr_word;
        end
    end

    assign beat.rd_beat_en = !hwrite_o && hready_i &&
                             ((state == S_MIDDLE) || (state == S_LAST_DATA));
    assign beat.beat_idx   = beat_cnt;
    assign beat.rd_data    = hrdata_i;
    assign cmd.cmd_done    = cmd_done_q;

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_no_seq_after_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (htrans_o == HTRANS_IDLE) |=> (htrans_o != HTRANS_SEQ));

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((htrans_o != HTRANS_IDLE) && !hready_i) |=> $stable(haddr_o));

endmodule

// ==== src/comp_data_port.sv ====
module comp_data_port (
    input  logic                                  clk,
    input  logic                                  rst_n,
    beat_if.port                                  beat,
    input  comp_engine_pkg::comp_sel_t            owner_i,
    input  comp_engine_pkg::comp_word_u           comp_rdata_i [comp_engine_pkg::NUM_COMP],
    output logic [comp_engine_pkg::BUF_AW-1:0]    buf_addr_o,
    output logic                                  comp_wren_o,
    output logic                                  comp_sop_o,
    output logic                                  comp_eop_o,
    output comp_engine_pkg::comp_word_u           comp_wdata_o
);
    import comp_engine_pkg::*;

    logic [3:0] pair_idx;
    logic       odd_beat;
    comp_word_u owner_word;

    assign pair_idx = beat.beat_idx[4:1];
    assign odd_beat = beat.beat_idx[0];

    // --------------------------------------------------
    // read side, two beats per compressor word
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            comp_wren_o <= 1'b0;
            comp_sop_o  <= 1'b0;
            comp_eop_o  <= 1'b0;
        end else begin
            comp_wren_o <= beat.rd_beat_en && odd_beat;
            comp_sop_o  <= beat.rd_beat_en && odd_beat && (pair_idx == '0);
            comp_eop_o  <= beat.rd_beat_en && odd_beat && (pair_idx == '1);
        end
    end

    always_ff @(posedge clk) begin
        if (beat.rd_beat_en) begin
            if (odd_beat) begin
                comp_wdata_o.beats.lo <= beat.rd_data;
            end else begin
                comp_wdata_o.beats.hi <= beat.rd_data;
            end
        end
    end

    // --------------------------------------------------
    // write side, buffer read is combinational
    // --------------------------------------------------
    assign buf_addr_o = beat.beat_idx[BUF_AW:1];

    // out-of-range owner falls back to buffer 0
    assign owner_word = (owner_i < NUM_COMP) ? comp_rdata_i[owner_i] : comp_rdata_i[0];

    // hi half goes out first
    assign beat.wr_word = odd_beat ? owner_word.beats.lo : owner_word.beats.hi;

    a_marks_with_wren: assert property (@(posedge clk) disable iff (!rst_n)
        (comp_sop_o || comp_eop_o) |-> comp_wren_o);

endmodule

// ==== src/comp_engine_top.sv ====
module comp_engine_top #(
    parameter int BLK_CNT_W = 25
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  comp_engine_pkg::addr_t                src_addr_i,
    input  comp_engine_pkg::addr_t                dst_addr_i,
    input  logic [BLK_CNT_W-1:0]                  len_i,
    input  logic                                  start_i,
    output logic                                  done_o,

    // bus master side
    output logic                                  hbusreq_o,
    input  logic                                  hgrant_i,
    output comp_engine_pkg::addr_t                haddr_o,
    output comp_engine_pkg::htrans_t              htrans_o,
    output logic                                  hwrite_o,
    output comp_engine_pkg::word_t                hwdata_o,
    input  comp_engine_pkg::word_t                hrdata_i,
    input  logic                                  hready_i,

    // compressors
    output logic                                  comp_wren_o,
    output logic                                  comp_sop_o,
    output logic                                  comp_eop_o,
    output comp_engine_pkg::comp_word_u           comp_wdata_o,
    input  logic [comp_engine_pkg::NUM_COMP-1:0]  comp_done_i,
    input  logic [comp_engine_pkg::NUM_COMP-1:0]  comp_fail_i,
    output logic [comp_engine_pkg::BUF_AW-1:0]    buf_addr_o,
    input  comp_engine_pkg::comp_word_u           comp_rdata_i [comp_engine_pkg::NUM_COMP]
);
    import comp_engine_pkg::*;

    comp_sel_t owner;

    burst_cmd_if cmd_bus ();
    beat_if      beat_bus ();

    block_sequencer #(
        .BLK_CNT_W (BLK_CNT_W)
    ) u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .len_i       (len_i),
        .start_i     (start_i),
        .done_o      (done_o),
        .comp_done_i (comp_done_i),
        .comp_fail_i (comp_fail_i),
        .owner_o     (owner),
        .cmd         (cmd_bus.source)
    );

    ahb_burst_master u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd_bus.sink),
        .beat      (beat_bus.master),
        .hbusreq_o (hbusreq_o),
        .hgrant_i  (hgrant_i),
        .haddr_o   (haddr_o),
        .htrans_o  (htrans_o),
        .hwrite_o  (hwrite_o),
        .hwdata_o  (hwdata_o),
        .hrdata_i  (hrdata_i),
        .hready_i  (hready_i)
    );

    comp_data_port u_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat         (beat_bus.port),
        .owner_i      (owner),
        .comp_rdata_i (comp_rdata_i),
        .buf_addr_o   (buf_addr_o),
        .comp_wren_o  (comp_wren_o),
        .comp_sop_o   (comp_sop_o),
        .comp_eop_o   (comp_eop_o),
        .comp_wdata_o (comp_wdata_o)
    );

endmodule

// ==== sim/ahb_mem_model.sv ====
module ahb_mem_model (
    input  logic                     clk,
    input  logic                     hbusreq_i,
    output logic                     hgrant_o,
    input  comp_engine_pkg::addr_t   haddr_i,
    input  comp_engine_pkg::htrans_t htrans_i,
    input  logic                     hwrite_i,
    input  comp_engine_pkg::word_t   hwdata_i,
    output comp_engine_pkg::word_t   hrdata_o,
    output logic                     hready_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import comp_engine_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int LOG_SIZE  = 4096;

    // word memory, indexed by address bits 11:2
    word_t mem [MEM_WORDS];

    // transfer logs, read by the testbench top
    addr_t rd_addr  [LOG_SIZE];
    logic  rd_first [LOG_SIZE];
    addr_t wr_addr  [LOG_SIZE];
    word_t wr_data  [LOG_SIZE];
    int    rd_cnt;
    int    wr_cnt;

    // data phase in flight
    logic  dp_valid;
    logic  dp_write;
    addr_t dp_addr;
    logic  req_seen;
    int    grant_wait;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom;
        end
        rd_cnt     = 0;
        wr_cnt     = 0;
        dp_valid   = 1'b0;
        dp_write   = 1'b0;
        dp_addr    = '0;
        req_seen   = 1'b0;
        grant_wait = 0;
        hgrant_o   = 1'b0;
        hrdata_o   = '0;
        hready_o   = 1'b1;
    end

    // --------------------------------------------------
    // sample mid-cycle, drive after the rising edge
    // --------------------------------------------------
    always begin
        @(negedge clk);
        req_seen = hbusreq_i;
        if (hready_o) begin
            // data phase completes at the coming edge
            if (dp_valid && dp_write) begin
                if (wr_cnt < LOG_SIZE) begin
                    wr_addr[wr_cnt] = dp_addr;
                    wr_data[wr_cnt] = hwdata_i;
                end
                wr_cnt++;
            end
            dp_valid = 1'b0;
            // address phase accepted
            if ((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ)) begin
                if (!hwrite_i) begin
                    if (rd_cnt < LOG_SIZE) begin
                        rd_addr[rd_cnt]  = haddr_i;
                        rd_first[rd_cnt] = (htrans_i == HTRANS_NONSEQ);
                    end
                    rd_cnt++;
                end
                dp_valid = 1'b1;
                dp_write = hwrite_i;
                dp_addr  = haddr_i;
            end
        end
        @(posedge clk);
        #2;
        // stall about one cycle in four
        hready_o = (($urandom % 4) != 0);
        hrdata_o = (dp_valid && !dp_write) ? mem[dp_addr[11:2]] : '0;
        if (req_seen !== 1'b1) begin
            hgrant_o   = 1'b0;
            grant_wait = $urandom % 4;
        end else if (!hgrant_o) begin
            if (grant_wait == 0) begin
                hgrant_o = 1'b1;
            end else begin
                grant_wait--;
            end
        end
    end

endmodule

// ==== sim/tb_comp_engine.sv ====
module tb_comp_engine;
    timeunit 1ns;
    timeprecision 100ps;
    import comp_engine_pkg::*;

    localparam int BLK_CNT_W = 25;
    localparam int TIMEOUT   = 5000;
    localparam int NUM_RUNS  = 20;

    logic                 clk;
    logic                 rst_n;
    addr_t                src_addr_i;
    addr_t                dst_addr_i;
    logic [BLK_CNT_W-1:0] len_i;
    logic                 start_i;
    logic                 done_o;
    logic                 hbusreq_o;
    logic                 hgrant_i;
    addr_t                haddr_o;
    htrans_t              htrans_o;
    logic                 hwrite_o;
    word_t                hwdata_o;
    word_t                hrdata_i;
    logic                 hready_i;
    logic                 comp_wren_o;
    logic                 comp_sop_o;
    logic                 comp_eop_o;
    comp_word_u           comp_wdata_o;
    logic [NUM_COMP-1:0]  comp_done_i;
    logic [NUM_COMP-1:0]  comp_fail_i;
    logic [BUF_AW-1:0]    buf_addr_o;
    comp_word_u           comp_rdata_i [NUM_COMP];

    // compressor model state
    comp_word_u cap [16];
    comp_sel_t  blk_owner [16];
    int         delay [NUM_COMP];
    int         words_seen;
    int         word_base;
    addr_t      job_src;
    int         fail_mode;
    logic       stalled;
    int         value_errors;
    int         other_errors;

    comp_engine_top #(
        .BLK_CNT_W (BLK_CNT_W)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .len_i        (len_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .hbusreq_o    (hbusreq_o),
        .hgrant_i     (hgrant_i),
        .haddr_o      (haddr_o),
        .htrans_o     (htrans_o),
        .hwrite_o     (hwrite_o),
        .hwdata_o     (hwdata_o),
        .hrdata_i     (hrdata_i),
        .hready_i     (hready_i),
        .comp_wren_o  (comp_wren_o),
        .comp_sop_o   (comp_sop_o),
        .comp_eop_o   (comp_eop_o),
        .comp_wdata_o (comp_wdata_o),
        .comp_done_i  (comp_done_i),
        .comp_fail_i  (comp_fail_i),
        .buf_addr_o   (buf_addr_o),
        .comp_rdata_i (comp_rdata_i)
    );

    ahb_mem_model mem0 (
        .clk       (clk),
        .hbusreq_i (hbusreq_o),
        .hgrant_o  (hgrant_i),
        .haddr_i   (haddr_o),
        .htrans_i  (htrans_o),
        .hwrite_i  (hwrite_o),
        .hwdata_i  (hwdata_o),
        .hrdata_o  (hrdata_i),
        .hready_o  (hready_i)
    );

    always #20 clk = ~clk;

    // result buffers, combinational read
    for (genvar k = 0; k < NUM_COMP; k++) begin : g_buf
        assign comp_rdata_i[k] = {cap[buf_addr_o].beats.hi ^ word_t'(k + 1),
                                  cap[buf_addr_o].beats.lo};
    end

    function automatic word_t mem_word(input addr_t addr);
        return mem0.mem[addr[11:2]];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        value_errors++;
        $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic finish_run();
        $display("%0d value errors, %0d other errors", value_errors, other_errors);
        if ((value_errors + other_errors) == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // compressor models
    // --------------------------------------------------
    always begin : comp_model
        int         idx;
        int         blk;
        int         w;
        int         eop_blk;
        addr_t      base;
        comp_word_u exp_word;
        comp_word_u cap_word;
        logic       cap_pend;
        logic       eop_pend;
        logic       found;
        comp_sel_t  owner;

        @(negedge clk);
        cap_pend = 1'b0;
        eop_pend = 1'b0;
        if (comp_wren_o === 1'b1) begin
            idx  = words_seen - word_base;
            blk  = idx / 16;
            w    = idx % 16;
            base = job_src + addr_t'(blk * 128 + w * 8);
            exp_word.beats.hi = mem_word(base);
            exp_word.beats.lo = mem_word(base + 4);
            if (comp_wdata_o !== exp_word) begin
                report_mismatch("comp_wdata_o", comp_wdata_o, exp_word);
            end
            if (comp_sop_o !== (w == 0)) begin
                report_mismatch("comp_sop_o", comp_sop_o, w == 0);
            end
            if (comp_eop_o !== (w == 15)) begin
                report_mismatch("comp_eop_o", comp_eop_o, w == 15);
            end
            cap_pend = 1'b1;
            cap_word = comp_wdata_o;
            eop_pend = (w == 15);
            eop_blk  = blk;
            words_seen++;
        end else if ((comp_sop_o === 1'b1) || (comp_eop_o === 1'b1)) begin
            report_failure("packet mark seen without a compressor write");
        end
        @(posedge clk);
        #2;
        if (cap_pend) begin
            cap[w] = cap_word;
            // new packet, drop the old done levels
            if (w == 0) begin
                comp_done_i = '0;
            end
        end
        for (int k = 0; k < NUM_COMP; k++) begin
            if (delay[k] > 0) begin
                delay[k]--;
                if (delay[k] == 0) begin
                    comp_done_i[k] = 1'b1;
                end
            end
        end
        if (eop_pend) begin
            case (fail_mode)
                1:       comp_fail_i = '1;
                2:       comp_fail_i = 3'b011;
                default: comp_fail_i = NUM_COMP'($urandom);
            endcase
            owner = '0;
            found = 1'b0;
            for (int k = 0; k < NUM_COMP; k++) begin
                if (!found && !comp_fail_i[k]) begin
                    owner = comp_sel_t'(k);
                    found = 1'b1;
                end
            end
            blk_owner[eop_blk % 16] = owner;
            for (int k = 0; k < NUM_COMP; k++) begin
                delay[k] = 1 + ($urandom % 10);
            end
        end
    end

    // start with zero length, nothing may move
    task automatic idle_start();
        @(posedge clk);
        #2;
        len_i   = '0;
        start_i = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        @(negedge clk);
        if (done_o !== 1'b1) begin
            report_mismatch("done_o", done_o, 1'b1);
        end
        for (int c = 0; c < 20; c++) begin
            if (hbusreq_o !== 1'b0) begin
                report_mismatch("hbusreq_o", hbusreq_o, 1'b0);
            end
            @(negedge clk);
        end
    endtask

    task automatic run_job(input addr_t src, input addr_t dst, input int len, input int mode);
        int        rd_base;
        int        wr_base;
        int        cyc;
        int        b;
        int        k;
        addr_t     exp_addr;
        word_t     exp_data;
        comp_sel_t owner;

        rd_base   = mem0.rd_cnt;
        wr_base   = mem0.wr_cnt;
        word_base = words_seen;
        job_src   = src;
        fail_mode = mode;
        @(posedge clk);
        #2;
        src_addr_i = src;
        dst_addr_i = dst;
        len_i      = BLK_CNT_W'(len);
        start_i    = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        cyc = 0;
        @(negedge clk);
        while ((done_o !== 1'b1) && (cyc < TIMEOUT)) begin
            @(negedge clk);
            cyc++;
        end
        if (done_o !== 1'b1) begin
            report_failure("timeout, done_o never came back high");
            stalled = 1'b1;
        end else begin
            // done_o high again only after the last write
            if ((mem0.wr_cnt - wr_base) != 16 * len) begin
                report_mismatch("hwdata_o beat count", mem0.wr_cnt - wr_base, 16 * len);
            end
            if ((mem0.rd_cnt - rd_base) != 32 * len) begin
                report_mismatch("read beat count", mem0.rd_cnt - rd_base, 32 * len);
            end
            if ((words_seen - word_base) != 16 * len) begin
                report_mismatch("comp_wren_o count", words_seen - word_base, 16 * len);
            end
            for (int n = 0; n < 32 * len; n++) begin
                b = n / 32;
                k = n % 32;
                exp_addr = src + addr_t'(b * 128 + 4 * k);
                if (mem0.rd_addr[rd_base + n] !== exp_addr) begin
                    report_mismatch("haddr_o read", mem0.rd_addr[rd_base + n], exp_addr);
                end
                if (mem0.rd_first[rd_base + n] !== ((k % 16) == 0)) begin
                    report_mismatch("htrans_o nonseq", mem0.rd_first[rd_base + n],
                                    (k % 16) == 0);
                end
            end
            for (int n = 0; n < 16 * len; n++) begin
                b = n / 16;
                k = n % 16;
                owner    = blk_owner[b];
                exp_addr = dst + addr_t'(b * 64 + 4 * k);
                exp_data = mem_word(src + addr_t'(b * 128 + 4 * k));
                if ((k % 2) == 0) begin
                    exp_data = exp_data ^ word_t'(owner + 1);
                end
                if (mem0.wr_addr[wr_base + n] !== exp_addr) begin
                    report_mismatch("haddr_o write", mem0.wr_addr[wr_base + n], exp_addr);
                end
                if (mem0.wr_data[wr_base + n] !== exp_data) begin
                    report_mismatch("hwdata_o", mem0.wr_data[wr_base + n], exp_data);
                end
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(27520));
        clk          = 1'b0;
        rst_n        = 1'b0;
        src_addr_i   = '0;
        dst_addr_i   = '0;
        len_i        = '0;
        start_i      = 1'b0;
        comp_done_i  = '0;
        comp_fail_i  = '0;
        words_seen   = 0;
        word_base    = 0;
        job_src      = '0;
        fail_mode    = 0;
        stalled      = 1'b0;
        value_errors = 0;
        other_errors = 0;
        for (int k = 0; k < NUM_COMP; k++) begin
            delay[k] = 0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (done_o !== 1'b1) begin
            report_mismatch("done_o", done_o, 1'b1);
        end
        if (hbusreq_o !== 1'b0) begin
            report_mismatch("hbusreq_o", hbusreq_o, 1'b0);
        end
        if (htrans_o !== HTRANS_IDLE) begin
            report_mismatch("htrans_o", htrans_o, HTRANS_IDLE);
        end
        if (comp_wren_o !== 1'b0) begin
            report_mismatch("comp_wren_o", comp_wren_o, 1'b0);
        end
        idle_start();
        // all compressors fail, then only compressor 2 succeeds
        run_job(addr_t'($urandom) & ~addr_t'(3), addr_t'($urandom) & ~addr_t'(3), 2, 1);
        if (!stalled) begin
            run_job(addr_t'($urandom) & ~addr_t'(3), addr_t'($urandom) & ~addr_t'(3), 2, 2);
        end
        for (int r = 0; (r < NUM_RUNS) && !stalled; r++) begin
            run_job(addr_t'($urandom) & ~addr_t'(3), addr_t'($urandom) & ~addr_t'(3),
                    1 + ($urandom % 4), 0);
        end
        finish_run();
    end

endmodule

// ==== files.f ====
src/comp_engine_pkg.sv
src/burst_cmd_if.sv
src/beat_if.sv
src/block_sequencer.sv
src/ahb_burst_master.sv
src/comp_data_port.sv
src/comp_engine_top.sv
sim/ahb_mem_model.sv
sim/tb_comp_engine.sv
